//--- a2f_macros.svh
`ifndef A2F_MACROS_SVH
`define A2F_MACROS_SVH

// AXI slave port widths
`define A2F_ADDR_W 7
`define A2F_DATA_W 128
`define A2F_ID_W 16
`define A2F_LEN_W 8

// Image geometry fields
`define A2F_IMG_W_W 12
`define A2F_IMG_H_W 11

// DRAM engine request address
`define A2F_DRAM_ADDR_W 39

`endif

//--- axi_slave_pkg.sv
package axi_slave_pkg;

    //////////////////////////////////////////////////////////////////////
    // Response codes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    //////////////////////////////////////////////////////////////////////
    // Channel state machines
    //////////////////////////////////////////////////////////////////////

    // One state per write target, then the response phase
    typedef enum logic [3:0] {
        WR_IDLE   = 4'h0,
        WR_FIFO   = 4'h2,
        WR_FLUSH  = 4'h3,
        WR_SIZE   = 4'h4,
        WR_BUFFER = 4'h5,
        WR_DONE   = 4'h6,
        WR_ERROR  = 4'h7,
        WR_RESP   = 4'h8
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'h0,
        RD_DRAM  = 2'h1,
        RD_ERROR = 2'h2
    } rd_state_t;

endpackage

//--- image_bridge_pkg.sv
`include "a2f_macros.svh"

package image_bridge_pkg;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [`A2F_ADDR_W-1:0] {
        REG_FIFO   = 7'h00,
        REG_FLUSH  = 7'h10,
        REG_SIZE   = 7'h20,
        REG_BUFFER = 7'h30,
        REG_DONE   = 7'h40
    } reg_map_t;

    // Read space reuses offset zero for the DRAM request word
    localparam reg_map_t REG_DRAM_REQ = REG_FIFO;

    //////////////////////////////////////////////////////////////////////
    // Write data word, pixel payload or size fields
    //////////////////////////////////////////////////////////////////////
    typedef union packed {
        logic [`A2F_DATA_W-1:0] raw;
        struct packed {
            logic [63:0] rsvd;
            logic [31:0] width;
            logic [31:0] height;
        } size;
    } data_word_u;

endpackage

//--- axi_write_engine.sv
`include "a2f_macros.svh"

module axi_write_engine (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic [`A2F_ADDR_W-1:0]        s_axi_awaddr,
    input  logic [`A2F_ID_W-1:0]          s_axi_awid,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [`A2F_DATA_W-1:0]        s_axi_wdata,
    input  logic                          s_axi_wvalid,
    input  logic                          s_axi_wlast,
    output logic                          s_axi_wready,
    input  logic                          s_axi_bready,
    output logic                          s_axi_bvalid,
    output axi_slave_pkg::axi_resp_t      s_axi_bresp,
    output logic [`A2F_ID_W-1:0]          s_axi_bid,
    input  logic                          image_sender_full,
    input  logic                          dram_buffer_full,
    output logic                          image_sender_write,
    output logic                          image_sender_flush,
    output logic [`A2F_DATA_W-1:0]        image_sender_fifo_din,
    output logic [`A2F_DATA_W-1:0]        dram_read_data,
    output logic                          dram_read_data_valid,
    output logic                          size_load,
    output image_bridge_pkg::data_word_u  size_word,
    output logic                          done_beat,
    output logic                          done_last,
    output logic                          write_idle
);

    axi_slave_pkg::wr_state_t wr_state;
    axi_slave_pkg::wr_state_t wr_next;
    logic [`A2F_ID_W-1:0]     awid_q;
    logic                     aw_fire;
    logic                     w_fire;
    logic                     resp_phase;

    assign aw_fire    = s_axi_awvalid && s_axi_awready;
    assign w_fire     = s_axi_wvalid && s_axi_wready;
    assign write_idle = (wr_state == axi_slave_pkg::WR_IDLE);
    assign resp_phase = (wr_state == axi_slave_pkg::WR_RESP) ||
                        (wr_state == axi_slave_pkg::WR_ERROR);

    // Back-pressure only on the two targets that can fill up
    always_comb begin
        case (wr_state)
            axi_slave_pkg::WR_FIFO:   s_axi_wready = !image_sender_full;
            axi_slave_pkg::WR_BUFFER: s_axi_wready = !dram_buffer_full;
            axi_slave_pkg::WR_FLUSH,
            axi_slave_pkg::WR_SIZE,
            axi_slave_pkg::WR_DONE:   s_axi_wready = 1'b1;
            default:                  s_axi_wready = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            axi_slave_pkg::WR_IDLE: begin
                if (aw_fire) begin
                    case (s_axi_awaddr)
                        image_bridge_pkg::REG_FIFO:   wr_next = axi_slave_pkg::WR_FIFO;
                        image_bridge_pkg::REG_FLUSH:  wr_next = axi_slave_pkg::WR_FLUSH;
                        image_bridge_pkg::REG_SIZE:   wr_next = axi_slave_pkg::WR_SIZE;
                        image_bridge_pkg::REG_BUFFER: wr_next = axi_slave_pkg::WR_BUFFER;
                        image_bridge_pkg::REG_DONE:   wr_next = axi_slave_pkg::WR_DONE;
                        default:                      wr_next = axi_slave_pkg::WR_ERROR;
                    endcase
                end
            end
            axi_slave_pkg::WR_FIFO,
            axi_slave_pkg::WR_FLUSH,
            axi_slave_pkg::WR_SIZE,
            axi_slave_pkg::WR_BUFFER,
            axi_slave_pkg::WR_DONE: begin
                if (w_fire && s_axi_wlast) begin
                    wr_next = axi_slave_pkg::WR_RESP;
                end
            end
            axi_slave_pkg::WR_RESP,
            axi_slave_pkg::WR_ERROR: begin
                if (s_axi_bready) begin
                    wr_next = axi_slave_pkg::WR_IDLE;
                end
            end
            default: wr_next = axi_slave_pkg::WR_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, handshakes and target strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_state             <= axi_slave_pkg::WR_IDLE;
            s_axi_awready        <= 1'b0;
            s_axi_bvalid         <= 1'b0;
            image_sender_write   <= 1'b0;
            image_sender_flush   <= 1'b0;
            dram_read_data_valid <= 1'b0;
            size_load            <= 1'b0;
            done_beat            <= 1'b0;
            done_last            <= 1'b0;
        end else begin
            wr_state      <= wr_next;
            // Registered so it stays low through the first cycle after reset
            s_axi_awready <= (wr_next == axi_slave_pkg::WR_IDLE);
            s_axi_bvalid  <= resp_phase && s_axi_bready;

            image_sender_write   <= w_fire && (wr_state == axi_slave_pkg::WR_FIFO);
            image_sender_flush   <= w_fire && (wr_state == axi_slave_pkg::WR_FLUSH) &&
                                    s_axi_wdata[0];
            dram_read_data_valid <= w_fire && (wr_state == axi_slave_pkg::WR_BUFFER);
            size_load            <= w_fire && (wr_state == axi_slave_pkg::WR_SIZE);
            done_beat            <= w_fire && (wr_state == axi_slave_pkg::WR_DONE);
            done_last            <= w_fire && (wr_state == axi_slave_pkg::WR_DONE) &&
                                    s_axi_wlast;
        end
    end

    // Payload and ID holding
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            awid_q <= s_axi_awid;
        end
        if (resp_phase && s_axi_bready) begin
            s_axi_bid   <= awid_q;
            s_axi_bresp <= (wr_state == axi_slave_pkg::WR_ERROR) ?
                           axi_slave_pkg::RESP_SLVERR : axi_slave_pkg::RESP_OKAY;
        end
        if (w_fire && (wr_state == axi_slave_pkg::WR_FIFO)) begin
            image_sender_fifo_din <= s_axi_wdata;
        end
        if (w_fire && (wr_state == axi_slave_pkg::WR_BUFFER)) begin
            dram_read_data <= s_axi_wdata;
        end
        if (w_fire && (wr_state == axi_slave_pkg::WR_SIZE)) begin
            size_word.raw <= s_axi_wdata;
        end
    end

endmodule

//--- axi_read_engine.sv
`include "a2f_macros.svh"

module axi_read_engine (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic [`A2F_ADDR_W-1:0]        s_axi_araddr,
    input  logic [`A2F_ID_W-1:0]          s_axi_arid,
    input  logic [`A2F_LEN_W-1:0]         s_axi_arlen,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    input  logic                          s_axi_rready,
    output logic                          s_axi_rvalid,
    output logic                          s_axi_rlast,
    output logic [`A2F_ID_W-1:0]          s_axi_rid,
    output logic [`A2F_DATA_W-1:0]        s_axi_rdata,
    output axi_slave_pkg::axi_resp_t      s_axi_rresp,
    input  logic [`A2F_DRAM_ADDR_W-1:0]   dram_read_addr,
    input  logic [`A2F_LEN_W-1:0]         dram_read_len
);

    axi_slave_pkg::rd_state_t rd_state;
    axi_slave_pkg::rd_state_t rd_next;
    logic [`A2F_LEN_W-1:0]    beats_left;
    logic                     ar_fire;
    logic                     r_fire;

    assign ar_fire = s_axi_arvalid && s_axi_arready;
    assign r_fire  = s_axi_rvalid && s_axi_rready;

    // Beat outputs follow the state directly
    assign s_axi_rvalid = (rd_state != axi_slave_pkg::RD_IDLE);
    assign s_axi_rlast  = (rd_state == axi_slave_pkg::RD_ERROR) ||
                          ((rd_state == axi_slave_pkg::RD_DRAM) && (beats_left == '0));
    assign s_axi_rresp  = (rd_state == axi_slave_pkg::RD_ERROR) ?
                          axi_slave_pkg::RESP_SLVERR : axi_slave_pkg::RESP_OKAY;

    // Length in bits 71:64, address in the low bits
    assign s_axi_rdata = (rd_state == axi_slave_pkg::RD_DRAM) ?
                         {{(64 - `A2F_LEN_W){1'b0}}, dram_read_len,
                          {(64 - `A2F_DRAM_ADDR_W){1'b0}}, dram_read_addr} : '0;

    always_comb begin
        rd_next = rd_state;
        if (rd_state == axi_slave_pkg::RD_IDLE) begin
            if (ar_fire) begin
                rd_next = (s_axi_araddr == image_bridge_pkg::REG_DRAM_REQ) ?
                          axi_slave_pkg::RD_DRAM : axi_slave_pkg::RD_ERROR;
            end
        end else if (r_fire && s_axi_rlast) begin
            rd_next = axi_slave_pkg::RD_IDLE;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_state      <= axi_slave_pkg::RD_IDLE;
            s_axi_arready <= 1'b0;
        end else begin
            rd_state      <= rd_next;
            s_axi_arready <= (rd_next == axi_slave_pkg::RD_IDLE);
        end
    end

    // Burst counter and ID, loaded at the address handshake
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            beats_left <= s_axi_arlen;
            s_axi_rid  <= s_axi_arid;
        end else if (r_fire && !s_axi_rlast) begin
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

//--- bridge_status_regs.sv
`include "a2f_macros.svh"

module bridge_status_regs (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic                          dram_read_en,
    input  logic                          size_load,
    input  image_bridge_pkg::data_word_u  size_word,
    input  logic                          done_beat,
    input  logic                          done_last,
    input  logic                          write_idle,
    output logic [`A2F_IMG_W_W-1:0]       image_width,
    output logic [`A2F_IMG_H_W-1:0]       image_height,
    output logic                          dram_read_busy,
    output logic                          irq_signal
);

    // Request outstanding, cleared by the first beat at REG_DONE
    logic read_pending;

    //////////////////////////////////////////////////////////////////////
    // Image geometry
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_width  <= '0;
            image_height <= '0;
        end else if (size_load) begin
            image_width  <= size_word.size.width[`A2F_IMG_W_W-1:0];
            image_height <= size_word.size.height[`A2F_IMG_H_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // DRAM request lifecycle and interrupt
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            read_pending   <= 1'b0;
            dram_read_busy <= 1'b0;
            irq_signal     <= 1'b0;
        end else begin
            if (done_beat) begin
                read_pending <= 1'b0;
            end
            if (done_last) begin
                irq_signal <= 1'b0;
            end
            // Busy only moves between write bursts
            if (write_idle) begin
                dram_read_busy <= read_pending;
                if (dram_read_en) begin
                    read_pending   <= 1'b1;
                    dram_read_busy <= 1'b1;
                    irq_signal     <= 1'b1;
                end
            end
        end
    end

endmodule

//--- axi2fifo_top.sv
`include "a2f_macros.svh"

module axi2fifo_top (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic [`A2F_ADDR_W-1:0]        s_axi_awaddr,
    input  logic [`A2F_ID_W-1:0]          s_axi_awid,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [`A2F_DATA_W-1:0]        s_axi_wdata,
    input  logic                          s_axi_wvalid,
    input  logic                          s_axi_wlast,
    output logic                          s_axi_wready,
    input  logic                          s_axi_bready,
    output logic                          s_axi_bvalid,
    output axi_slave_pkg::axi_resp_t      s_axi_bresp,
    output logic [`A2F_ID_W-1:0]          s_axi_bid,
    input  logic [`A2F_ADDR_W-1:0]        s_axi_araddr,
    input  logic [`A2F_ID_W-1:0]          s_axi_arid,
    input  logic [`A2F_LEN_W-1:0]         s_axi_arlen,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    input  logic                          s_axi_rready,
    output logic                          s_axi_rvalid,
    output logic                          s_axi_rlast,
    output logic [`A2F_ID_W-1:0]          s_axi_rid,
    output logic [`A2F_DATA_W-1:0]        s_axi_rdata,
    output axi_slave_pkg::axi_resp_t      s_axi_rresp,
    output logic                          image_sender_reset,
    output logic                          image_sender_flush,
    output logic                          image_sender_write,
    output logic [`A2F_DATA_W-1:0]        image_sender_fifo_din,
    output logic [`A2F_IMG_W_W-1:0]       image_width,
    output logic [`A2F_IMG_H_W-1:0]       image_height,
    input  logic                          image_sender_full,
    input  logic [`A2F_DRAM_ADDR_W-1:0]   dram_read_addr,
    input  logic [`A2F_LEN_W-1:0]         dram_read_len,
    input  logic                          dram_read_en,
    input  logic                          dram_buffer_full,
    output logic [`A2F_DATA_W-1:0]        dram_read_data,
    output logic                          dram_read_data_valid,
    output logic                          dram_read_busy,
    output logic                          irq_signal
);

    // Write engine to status block
    logic                         size_load;
    image_bridge_pkg::data_word_u size_word;
    logic                         done_beat;
    logic                         done_last;
    logic                         write_idle;

    assign image_sender_reset = ~s_axi_aresetn;

    axi_write_engine u_write (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_awaddr, .s_axi_awid, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wlast, .s_axi_wready,
        .s_axi_bready, .s_axi_bvalid, .s_axi_bresp, .s_axi_bid,
        .image_sender_full, .dram_buffer_full,
        .image_sender_write, .image_sender_flush, .image_sender_fifo_din,
        .dram_read_data, .dram_read_data_valid,
        .size_load, .size_word, .done_beat, .done_last, .write_idle
    );

    axi_read_engine u_read (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_araddr, .s_axi_arid, .s_axi_arlen, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rready, .s_axi_rvalid, .s_axi_rlast, .s_axi_rid, .s_axi_rdata,
        .s_axi_rresp, .dram_read_addr, .dram_read_len
    );

    bridge_status_regs u_status (
        .s_axi_aclk, .s_axi_aresetn,
        .dram_read_en, .size_load, .size_word, .done_beat, .done_last, .write_idle,
        .image_width, .image_height, .dram_read_busy, .irq_signal
    );

endmodule

//--- axi2fifo_asserts.sv
module axi2fifo_asserts (
    input logic       clk,
    input logic       resetn,
    input logic [3:0] wr_state,
    input logic       image_sender_full,
    input logic       awready, wready, arready, bvalid, rvalid, rready, rlast,
    input logic       fifo_write, fifo_flush, buffer_valid, irq, busy
);
    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clk) disable iff (!resetn) bvalid |=> !bvalid)
        else $error("bvalid stayed high for more than one cycle");

    // A beat refused while full never reaches the FIFO write strobe
    assert property (@(posedge clk) disable iff (!resetn)
        (wr_state == axi_slave_pkg::WR_FIFO && image_sender_full) |=> !fifo_write)
        else $error("image_sender_write after a cycle with image_sender_full in the FIFO state");

    // Stalled read beat holds until rready
    assert property (@(posedge clk) disable iff (!resetn)
        (rvalid && !rready) |=> (rvalid && $stable(rlast)))
        else $error("rvalid or rlast changed while the read beat was stalled");

    assert property (@(posedge clk) !resetn |=> !(awready || wready || arready || bvalid ||
        rvalid || rlast || fifo_write || fifo_flush || buffer_valid || irq || busy))
        else $error("control output high in the cycle after reset");

endmodule

bind axi2fifo_top axi2fifo_asserts u_asserts (
    .clk(s_axi_aclk), .resetn(s_axi_aresetn), .wr_state(u_write.wr_state),
    .image_sender_full(image_sender_full), .awready(s_axi_awready),
    .wready(s_axi_wready), .arready(s_axi_arready), .bvalid(s_axi_bvalid),
    .rvalid(s_axi_rvalid), .rready(s_axi_rready), .rlast(s_axi_rlast),
    .fifo_write(image_sender_write),
    .fifo_flush(image_sender_flush), .buffer_valid(dram_read_data_valid),
    .irq(irq_signal), .busy(dram_read_busy)
);

//--- tb_axi2fifo.sv
`include "a2f_macros.svh"

module tb_axi2fifo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] K_WR = 2'd0, K_RD = 2'd1, K_EN = 2'd2;
    localparam logic [127:0] SIZE_WORD = {64'h0, 32'habcd_5a80, 32'h1234_f437};

    // One table row: kind, address, burst length, data source, stall pattern, response
    typedef struct {
        logic [1:0]   kind;
        logic [6:0]   addr;
        logic [7:0]   len;
        logic         use_rng;
        logic [127:0] word;
        logic [15:0]  hold;
        logic [1:0]   resp;
        logic         chk_st;
        logic [1:0]   exp_st;
    } test_t;

    logic s_axi_aclk, s_axi_aresetn;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wlast, s_axi_wready;
    logic s_axi_bready, s_axi_bvalid, s_axi_arvalid, s_axi_arready;
    logic s_axi_rready, s_axi_rvalid, s_axi_rlast;
    logic [1:0] s_axi_bresp, s_axi_rresp;
    logic [`A2F_ADDR_W-1:0] s_axi_awaddr, s_axi_araddr;
    logic [`A2F_ID_W-1:0] s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
    logic [`A2F_LEN_W-1:0] s_axi_arlen, dram_read_len;
    logic [`A2F_DATA_W-1:0] s_axi_wdata, s_axi_rdata, image_sender_fifo_din, dram_read_data;
    logic image_sender_reset, image_sender_flush, image_sender_write, image_sender_full;
    logic [`A2F_IMG_W_W-1:0] image_width;
    logic [`A2F_IMG_H_W-1:0] image_height;
    logic [`A2F_DRAM_ADDR_W-1:0] dram_read_addr;
    logic dram_read_en, dram_buffer_full, dram_read_data_valid, dram_read_busy, irq_signal;

    test_t tests[$];
    logic [128:0] got_q[$], exp_q[$];
    logic [31:0] rng_state;
    logic [1:0] resp_st;
    int got_flush = 0, exp_flush = 0, errors = 0, test_errs = 0, failed = 0;
    int cycles = 0, cycle_limit = 0;

    axi2fifo_top uut (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #4 s_axi_aclk = ~s_axi_aclk;
    end

    always @(posedge s_axi_aclk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Strobe capture, tagged 0 for image FIFO and 1 for DRAM buffer
    always @(negedge s_axi_aclk) begin
        if (image_sender_write) got_q.push_back({1'b0, image_sender_fifo_din});
        if (dram_read_data_valid) got_q.push_back({1'b1, dram_read_data});
        if (image_sender_flush) got_flush = got_flush + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [127:0] next_word();
        logic [127:0] w;
        for (int i = 0; i < 4; i++) begin
            rng_state = rng_state * 32'd1103515245 + 32'd12345;
            w[i*32 +: 32] = rng_state;
        end
        return w;
    endfunction

    function automatic logic [127:0] beat_word(input test_t t);
        if (t.use_rng) return next_word();
        return t.word;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        test_errs++;
        $display("ERROR at %0t ns: %0s", $time, msg);
    endtask

    task automatic write_burst(input test_t t, input logic [15:0] id);
        int b;
        int c;
        logic [127:0] data;
        b = 0;
        c = 0;
        @(negedge s_axi_aclk);
        s_axi_awaddr = t.addr;
        s_axi_awid = id;
        s_axi_awvalid = 1'b1;
        #1;
        while (!s_axi_awready) begin
            @(negedge s_axi_aclk);
            #1;
        end
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        // Unmapped targets take no beats
        if (t.resp == 2'b00) begin
            data = beat_word(t);
            while (b <= int'(t.len)) begin
                s_axi_wdata = data;
                s_axi_wvalid = 1'b1;
                s_axi_wlast = (b == int'(t.len));
                image_sender_full = (c < 16) && t.hold[c[3:0]];
                dram_buffer_full = image_sender_full;
                #1;
                if (s_axi_wready) begin
                    case (t.addr)
                        7'h00: exp_q.push_back({1'b0, data});
                        7'h30: exp_q.push_back({1'b1, data});
                        7'h10: exp_flush += int'(data[0]);
                        default: ;
                    endcase
                    b++;
                    if (b <= int'(t.len)) data = beat_word(t);
                end
                @(negedge s_axi_aclk);
                c++;
            end
            s_axi_wvalid = 1'b0;
            s_axi_wlast = 1'b0;
            image_sender_full = 1'b0;
            dram_buffer_full = 1'b0;
        end
        while (!s_axi_bvalid) @(negedge s_axi_aclk);
        assert (s_axi_bid == id)
            else report_mismatch($sformatf("bid %h, expected %h", s_axi_bid, id));
        assert (s_axi_bresp == t.resp)
            else report_mismatch($sformatf("bresp %0d, expected %0d", s_axi_bresp, t.resp));
        resp_st = {irq_signal, dram_read_busy};
        @(negedge s_axi_aclk);
    endtask

    task automatic read_burst(input test_t t, input logic [15:0] id);
        int b;
        int c;
        int nbeats;
        logic [127:0] exp_data;
        b = 0;
        c = 0;
        nbeats = 1;
        exp_data = '0;
        if (t.resp == 2'b00) begin
            exp_data[71:64] = dram_read_len;
            exp_data[38:0] = dram_read_addr;
            nbeats = int'(t.len) + 1;
        end
        @(negedge s_axi_aclk);
        s_axi_araddr = t.addr;
        s_axi_arid = id;
        s_axi_arlen = t.len;
        s_axi_arvalid = 1'b1;
        #1;
        while (!s_axi_arready) begin
            @(negedge s_axi_aclk);
            #1;
        end
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        while (b < nbeats) begin
            s_axi_rready = !((c < 16) && t.hold[c[3:0]]);
            #1;
            if (s_axi_rvalid && s_axi_rready) begin
                assert (s_axi_rdata == exp_data)
                    else report_mismatch($sformatf("rdata %h, expected %h", s_axi_rdata, exp_data));
                assert (s_axi_rresp == t.resp && s_axi_rid == id)
                    else report_mismatch($sformatf("rresp %0d rid %h", s_axi_rresp, s_axi_rid));
                assert (s_axi_rlast == (b == nbeats - 1))
                    else report_mismatch($sformatf("rlast %b on beat %0d", s_axi_rlast, b));
                b++;
            end
            @(negedge s_axi_aclk);
            c++;
        end
        s_axi_rready = 1'b0;
    endtask

    task automatic pulse_read_en();
        @(negedge s_axi_aclk);
        dram_read_en = 1'b1;
        @(negedge s_axi_aclk);
        dram_read_en = 1'b0;
        @(negedge s_axi_aclk);
    endtask

    task automatic check_results(input test_t t);
        assert (got_q.size() == exp_q.size())
            else report_mismatch($sformatf("%0d strobes, expected %0d", got_q.size(), exp_q.size()));
        for (int k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
            assert (got_q[k] == exp_q[k])
                else report_mismatch($sformatf("strobe %0d is %h, expected %h",
                                               k, got_q[k], exp_q[k]));
        end
        assert (got_flush == exp_flush)
            else report_mismatch($sformatf("%0d flush pulses, expected %0d", got_flush, exp_flush));
        if (t.kind == K_WR && t.addr == 7'h20) begin
            assert (image_width == t.word[32 +: 12] && image_height == t.word[0 +: 11])
                else report_mismatch($sformatf("size %h x %h", image_width, image_height));
        end
        // Interrupt drops before the busy flag
        if (t.kind == K_WR && t.addr == 7'h40) begin
            assert (resp_st == 2'b01)
                else report_mismatch($sformatf("irq,busy %b at response, expected 01", resp_st));
        end
        if (t.chk_st) begin
            assert ({irq_signal, dram_read_busy} == t.exp_st)
                else report_mismatch($sformatf("irq,busy %b, expected %b",
                                                {irq_signal, dram_read_busy}, t.exp_st));
        end
        got_q.delete();
        exp_q.delete();
        got_flush = 0;
        exp_flush = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test table and sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        s_axi_aresetn = 1'b0;
        {s_axi_awvalid, s_axi_wvalid, s_axi_wlast, s_axi_arvalid, s_axi_rready} = '0;
        s_axi_bready = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awid = '0;
        s_axi_wdata = '0;
        s_axi_araddr = '0;
        s_axi_arid = '0;
        s_axi_arlen = '0;
        {image_sender_full, dram_buffer_full, dram_read_en} = '0;
        dram_read_addr = 39'h5a_1234_5678;
        dram_read_len = 8'ha7;
        rng_state = 32'd87755;

        tests.push_back(test_t'{K_WR, 7'h00, 8'd3, 1'b1, 128'h0, 16'h0000, 2'b00, 1'b0, 2'b00});
        tests.push_back(test_t'{K_WR, 7'h00, 8'd5, 1'b1, 128'h0, 16'h003c, 2'b00, 1'b0, 2'b00});
        tests.push_back(test_t'{K_WR, 7'h10, 8'd0, 1'b0, 128'h1, 16'h0000, 2'b00, 1'b0, 2'b00});
        tests.push_back(test_t'{K_WR, 7'h10, 8'd0, 1'b0, 128'h2, 16'h0000, 2'b00, 1'b0, 2'b00});
        tests.push_back(test_t'{K_WR, 7'h20, 8'd0, 1'b0, SIZE_WORD, 16'h0000, 2'b00, 1'b0, 2'b00});
        tests.push_back(test_t'{K_EN, 7'h00, 8'd0, 1'b0, 128'h0, 16'h0000, 2'b00, 1'b1, 2'b11});
        tests.push_back(test_t'{K_RD, 7'h00, 8'd2, 1'b0, 128'h0, 16'h0002, 2'b00, 1'b1, 2'b11});
        tests.push_back(test_t'{K_WR, 7'h30, 8'd2, 1'b1, 128'h0, 16'h0006, 2'b00, 1'b1, 2'b11});
        tests.push_back(test_t'{K_WR, 7'h40, 8'd0, 1'b0, 128'h0, 16'h0000, 2'b00, 1'b1, 2'b00});
        tests.push_back(test_t'{K_WR, 7'h50, 8'd0, 1'b0, 128'h0, 16'h0000, 2'b10, 1'b0, 2'b00});
        tests.push_back(test_t'{K_RD, 7'h10, 8'd0, 1'b0, 128'h0, 16'h0000, 2'b10, 1'b0, 2'b00});

        cycle_limit = 200;
        foreach (tests[i]) cycle_limit += (int'(tests[i].len) + 1) * 20;

        repeat (2) @(negedge s_axi_aclk);
        assert (image_sender_reset == 1'b1)
            else report_mismatch($sformatf("image_sender_reset %b in reset, expected 1",
                                           image_sender_reset));
        s_axi_aresetn = 1'b1;
        #1;
        assert (image_sender_reset == 1'b0)
            else report_mismatch($sformatf("image_sender_reset %b after reset, expected 0",
                                           image_sender_reset));

        for (int i = 0; i < tests.size(); i++) begin
            test_errs = 0;
            case (tests[i].kind)
                K_WR: write_burst(tests[i], 16'ha000 + 16'(i));
                K_RD: read_burst(tests[i], 16'ha000 + 16'(i));
                default: pulse_read_en();
            endcase
            check_results(tests[i]);
            if (test_errs != 0) failed++;
            $display("Test %0d kind %0d addr 0x%02h: %0s", i, tests[i].kind, tests[i].addr,
                     (test_errs == 0) ? "ok" : "mismatch");
        end

        $display("Tests run %0d, failed %0d, errors %0d", tests.size(), failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
axi_slave_pkg.sv
image_bridge_pkg.sv
axi_write_engine.sv
axi_read_engine.sv
bridge_status_regs.sv
axi2fifo_top.sv
axi2fifo_asserts.sv
tb_axi2fifo.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_axi2fifo
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
